//--- common/periph_cfg.svh
`ifndef PERIPH_CFG_SVH
`define PERIPH_CFG_SVH

// APB address width, byte addresses
`define PERIPH_ADDR_W 8

// UART transmit queue
`define PERIPH_FIFO_DEPTH 4

// GPIO widths
`define PERIPH_LED_W 8
`define PERIPH_SW_W 4

// bit period scaler, clocks per bit minus one
`define PERIPH_SCALER_W 16
`define PERIPH_SCALER_RST 16'd3

`endif

//--- common/periph_pkg.sv
`include "periph_cfg.svh"

package periph_pkg;

  // ==============================
  // APB request from the requester
  // ==============================
  typedef struct packed {
    logic                      psel;
    logic                      penable;
    logic                      pwrite;
    logic [`PERIPH_ADDR_W-1:0] paddr;
    logic [31:0]               pwdata;
  } apb_req_t;

  // register offsets
  typedef enum logic [`PERIPH_ADDR_W-1:0] {
    REG_GPIO_OUT    = 8'h00,
    REG_GPIO_DIR    = 8'h04,
    REG_GPIO_IN     = 8'h08,
    REG_UART_DATA   = 8'h0C,
    REG_UART_STATUS = 8'h10,
    REG_UART_SCALER = 8'h14
  } reg_addr_e;

  // serializer frame phases
  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } tx_state_e;

  // byte handed from the register write to the queue
  typedef struct packed {
    logic       valid;
    logic [7:0] data;
  } fifo_push_t;

endpackage

//--- verilog/apb_decoder.sv
`timescale 1ns/1ps
`include "periph_cfg.svh"

module apb_decoder
  import periph_pkg::*;
(
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  apb_req_t                    i_req,
  output logic [31:0]                 o_prdata,
  output logic                        o_pready,
  output logic                        o_pslverr,
  output logic                        o_gpio_we,
  output reg_addr_e                   o_gpio_sel,
  output logic [`PERIPH_LED_W-1:0]    o_wdata,
  input  logic [`PERIPH_LED_W-1:0]    i_gpio_rdata,
  input  logic                        i_fifo_full,
  input  logic                        i_fifo_empty,
  input  logic                        i_tx_busy,
  output fifo_push_t                  o_push,
  output logic [`PERIPH_SCALER_W-1:0] o_scaler
);

  logic      access;
  logic      wr;
  logic      mapped;
  logic      rd_only;
  reg_addr_e addr;

  assign addr   = reg_addr_e'(i_req.paddr);
  assign access = i_req.psel & i_req.penable;
  assign wr     = access & i_req.pwrite;

  // no wait states
  assign o_pready = access;

  always_comb begin
    mapped   = 1'b1;
    rd_only  = 1'b0;
    o_prdata = '0;
    case (addr)
      REG_GPIO_OUT, REG_GPIO_DIR: o_prdata = 32'(i_gpio_rdata);
      REG_GPIO_IN: begin
        rd_only  = 1'b1;
        o_prdata = 32'(i_gpio_rdata);
      end
      // write-only register reads as zero
      REG_UART_DATA: o_prdata = '0;
      REG_UART_STATUS: begin
        rd_only  = 1'b1;
        o_prdata = {29'd0, i_fifo_empty, i_tx_busy, i_fifo_full};
      end
      REG_UART_SCALER: o_prdata = 32'(o_scaler);
      default: mapped = 1'b0;
    endcase
  end

  assign o_pslverr = access & (~mapped | (i_req.pwrite & rd_only) |
                     (i_req.pwrite & (addr == REG_UART_DATA) & i_fifo_full));

  // gpio decodes the target register from the select
  assign o_gpio_we  = wr & ((addr == REG_GPIO_OUT) | (addr == REG_GPIO_DIR));
  assign o_gpio_sel = addr;
  assign o_wdata    = i_req.pwdata[`PERIPH_LED_W-1:0];

  // dropped when the queue is full
  assign o_push.valid = wr & (addr == REG_UART_DATA) & ~i_fifo_full;
  assign o_push.data  = i_req.pwdata[7:0];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_scaler <= `PERIPH_SCALER_RST;
    end else if (wr && addr == REG_UART_SCALER) begin
      o_scaler <= i_req.pwdata[`PERIPH_SCALER_W-1:0];
    end
  end

  // ==============================
  // protocol checks
  a_setup_then_ready: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_req.psel && !i_req.penable) |=> (i_req.penable && o_pready));

endmodule

//--- verilog/gpio_regs.sv
`timescale 1ns/1ps
`include "periph_cfg.svh"

module gpio_regs
  import periph_pkg::*;
(
  input  logic                     clk,
  input  logic                     i_arst_n,
  input  logic                     i_we,
  input  reg_addr_e                i_sel,
  input  logic [`PERIPH_LED_W-1:0] i_wdata,
  input  logic [`PERIPH_SW_W-1:0]  i_sw,
  output logic [`PERIPH_LED_W-1:0] o_rdata,
  output logic [`PERIPH_LED_W-1:0] o_led,
  output logic [`PERIPH_LED_W-1:0] o_led_oe
);

  logic [`PERIPH_LED_W-1:0] out_q;
  logic [`PERIPH_LED_W-1:0] dir_q;
  logic [`PERIPH_SW_W-1:0]  sw_meta_q;
  logic [`PERIPH_SW_W-1:0]  sw_sync_q;

  // ==============================
  // output and direction
  // ==============================
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      out_q <= '0;
      dir_q <= '0;
    end else if (i_we) begin
      if (i_sel == REG_GPIO_OUT) begin
        out_q <= i_wdata;
      end
      if (i_sel == REG_GPIO_DIR) begin
        dir_q <= i_wdata;
      end
    end
  end

  assign o_led    = out_q;
  // a pin drives only when its direction bit is set
  assign o_led_oe = dir_q;

  // two flop synchronizer, switches are asynchronous to clk
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sw_meta_q <= '0;
      sw_sync_q <= '0;
    end else begin
      sw_meta_q <= i_sw;
      sw_sync_q <= sw_meta_q;
    end
  end

  // read mux
  always_comb begin
    case (i_sel)
      REG_GPIO_OUT: o_rdata = out_q;
      REG_GPIO_DIR: o_rdata = dir_q;
      REG_GPIO_IN:  o_rdata = `PERIPH_LED_W'(sw_sync_q);
      default:      o_rdata = '0;
    endcase
  end

endmodule

//--- uart/uart_tx_fifo.sv
`timescale 1ns/1ps
`include "periph_cfg.svh"

module uart_tx_fifo
  import periph_pkg::*;
(
  input  logic       clk,
  input  logic       i_arst_n,
  input  fifo_push_t i_push,
  input  logic       i_pop,
  output logic [7:0] o_data,
  output logic       o_valid,
  output logic       o_full,
  output logic       o_empty
);

  localparam int PTR_W = $clog2(`PERIPH_FIFO_DEPTH);

  logic [7:0]     mem [`PERIPH_FIFO_DEPTH];
  // extra msb tells full from empty
  logic [PTR_W:0] wr_ptr_q;
  logic [PTR_W:0] rd_ptr_q;

  assign o_empty = (wr_ptr_q == rd_ptr_q);
  assign o_full  = (wr_ptr_q[PTR_W] != rd_ptr_q[PTR_W]) &&
                   (wr_ptr_q[PTR_W-1:0] == rd_ptr_q[PTR_W-1:0]);
  assign o_valid = ~o_empty;
  assign o_data  = mem[rd_ptr_q[PTR_W-1:0]];

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (i_push.valid && !o_full) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (i_pop && !o_empty) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_push.valid && !o_full) begin
      mem[wr_ptr_q[PTR_W-1:0]] <= i_push.data;
    end
  end

  // ==============================
  // the decoder and serializer must respect the flags
  a_no_push_full: assert property (@(posedge clk) disable iff (!i_arst_n)
    !(i_push.valid && o_full));

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!i_arst_n)
    !(i_pop && o_empty));

endmodule

//--- uart/uart_tx_serializer.sv
`timescale 1ns/1ps
`include "periph_cfg.svh"

module uart_tx_serializer
  import periph_pkg::*;
(
  input  logic                        clk,
  input  logic                        i_arst_n,
  input  logic [7:0]                  i_data,
  input  logic                        i_valid,
  input  logic [`PERIPH_SCALER_W-1:0] i_scaler,
  output logic                        o_pop,
  output logic                        o_busy,
  output logic                        o_td
);

  tx_state_e                   state_q;
  logic [2:0]                  bit_cnt_q;
  logic [`PERIPH_SCALER_W-1:0] clk_cnt_q;
  logic [7:0]                  shift_q;
  logic                        bit_end;

  // >= so a smaller scaler written mid-bit still ends the bit
  assign bit_end = (clk_cnt_q >= i_scaler);
  assign o_pop   = (state_q == IDLE) & i_valid;
  assign o_busy  = (state_q != IDLE);

  always_comb begin
    case (state_q)
      START:   o_td = 1'b0;
      DATA:    o_td = shift_q[0];
      default: o_td = 1'b1;
    endcase
  end

  // ==============================
  // frame sequencing
  // ==============================
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q   <= IDLE;
      bit_cnt_q <= '0;
      clk_cnt_q <= '0;
    end else begin
      if (state_q == IDLE || bit_end) begin
        clk_cnt_q <= '0;
      end else begin
        clk_cnt_q <= clk_cnt_q + 1'b1;
      end
      case (state_q)
        IDLE: begin
          if (i_valid) begin
            state_q <= START;
          end
        end
        START: begin
          if (bit_end) begin
            bit_cnt_q <= '0;
            state_q   <= DATA;
          end
        end
        DATA: begin
          if (bit_end) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == 3'd7) begin
              state_q <= STOP;
            end
          end
        end
        default: begin
          if (bit_end) begin
            state_q <= IDLE;
          end
        end
      endcase
    end
  end

  // lsb first
  always_ff @(posedge clk) begin
    if (o_pop) begin
      shift_q <= i_data;
    end else if (state_q == DATA && bit_end) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  // line was already high before and stays high while idle
  a_idle_line_high: assert property (@(posedge clk) disable iff (!i_arst_n)
    (state_q == IDLE) |-> (o_td && $past(o_td)));

endmodule

//--- verilog/periph_top.sv
`timescale 1ns/1ps
`include "periph_cfg.svh"

module periph_top
  import periph_pkg::*;
(
  input  logic                     clk,
  input  logic                     i_arst_n,
  input  apb_req_t                 i_req,
  output logic [31:0]              o_prdata,
  output logic                     o_pready,
  output logic                     o_pslverr,
  input  logic [`PERIPH_SW_W-1:0]  i_sw,
  output logic [`PERIPH_LED_W-1:0] o_led,
  output logic [`PERIPH_LED_W-1:0] o_led_oe,
  output logic                     o_uart_td
);

  logic                        gpio_we;
  reg_addr_e                   gpio_sel;
  logic [`PERIPH_LED_W-1:0]    gpio_wdata;
  logic [`PERIPH_LED_W-1:0]    gpio_rdata;
  fifo_push_t                  push;
  logic                        fifo_full;
  logic                        fifo_empty;
  logic                        fifo_valid;
  logic [7:0]                  fifo_data;
  logic                        tx_pop;
  logic                        tx_busy;
  logic [`PERIPH_SCALER_W-1:0] scaler;

  apb_decoder u_decoder (
    .clk          (clk),
    .i_arst_n     (i_arst_n),
    .i_req        (i_req),
    .o_prdata     (o_prdata),
    .o_pready     (o_pready),
    .o_pslverr    (o_pslverr),
    .o_gpio_we    (gpio_we),
    .o_gpio_sel   (gpio_sel),
    .o_wdata      (gpio_wdata),
    .i_gpio_rdata (gpio_rdata),
    .i_fifo_full  (fifo_full),
    .i_fifo_empty (fifo_empty),
    .i_tx_busy    (tx_busy),
    .o_push       (push),
    .o_scaler     (scaler)
  );

  gpio_regs u_gpio (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_we     (gpio_we),
    .i_sel    (gpio_sel),
    .i_wdata  (gpio_wdata),
    .i_sw     (i_sw),
    .o_rdata  (gpio_rdata),
    .o_led    (o_led),
    .o_led_oe (o_led_oe)
  );

  // ==============================
  // uart path, queue then shifter
  uart_tx_fifo u_fifo (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_push   (push),
    .i_pop    (tx_pop),
    .o_data   (fifo_data),
    .o_valid  (fifo_valid),
    .o_full   (fifo_full),
    .o_empty  (fifo_empty)
  );

  uart_tx_serializer u_serializer (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_data   (fifo_data),
    .i_valid  (fifo_valid),
    .i_scaler (scaler),
    .o_pop    (tx_pop),
    .o_busy   (tx_busy),
    .o_td     (o_uart_td)
  );

endmodule

//--- test/uart_rx_monitor.sv
`timescale 1ns/1ps

module uart_rx_monitor (
  input  logic       clk,
  input  logic       i_rx,
  input  int         i_clks_per_bit,
  output logic       o_valid,
  output logic [7:0] o_data,
  output int         o_bit_clks,
  output logic       o_stop_ok
);

  int         n;
  int         idx;
  int         run;
  int         zeros;
  logic       in_run;
  logic       stop;
  logic [7:0] shift;

  // ==============================
  // 8N1 receiver, samples on the falling clock edge
  // ==============================
  initial begin
    o_valid    = 1'b0;
    o_data     = '0;
    o_bit_clks = 0;
    o_stop_ok  = 1'b0;
    forever begin
      @(negedge clk);
      o_valid = 1'b0;
      if (i_rx === 1'b0) begin
        in_run = 1'b1;
        run    = 0;
        stop   = 1'b0;
        shift  = '0;
        // n counts clocks since the first low sample
        for (n = 1; n <= 9 * i_clks_per_bit + i_clks_per_bit / 2; n++) begin
          @(negedge clk);
          if (in_run && i_rx === 1'b1) begin
            in_run = 1'b0;
            run    = n;
          end
          if (n % i_clks_per_bit == i_clks_per_bit / 2) begin
            idx = n / i_clks_per_bit;
            if (idx >= 1 && idx <= 8) begin
              shift[idx-1] = i_rx;
            end else if (idx == 9) begin
              stop = i_rx;
            end
          end
        end
        // the low run covers the start bit plus any zero lsbs
        zeros = 0;
        while (zeros < 8 && !shift[zeros]) begin
          zeros++;
        end
        o_bit_clks = run / (1 + zeros);
        o_data     = shift;
        o_stop_ok  = stop;
        o_valid    = 1'b1;
      end
    end
  end

endmodule

//--- test/periph_top_tb.sv
`timescale 1ns/1ps
`include "periph_cfg.svh"

module periph_top_tb
  import periph_pkg::*;
();

  localparam int DEPTH      = `PERIPH_FIFO_DEPTH;
  localparam int RST_CPB    = `PERIPH_SCALER_RST + 1;
  localparam int N_UART     = 4;
  localparam int N_BP       = DEPTH + 2;
  localparam int NEW_SCALER = 9;
  localparam int N_SCALE    = 3;
  // one back-pressure write is refused and never sent
  localparam int WD_CYCLES  = (N_UART + N_BP - 1) * 10 * RST_CPB +
                              N_SCALE * 10 * (NEW_SCALER + 1) + 200;

  logic                     clk;
  logic                     arst_n;
  apb_req_t                 req;
  logic [31:0]              prdata;
  logic                     pready;
  logic                     pslverr;
  logic [`PERIPH_SW_W-1:0]  sw;
  logic [`PERIPH_LED_W-1:0] led;
  logic [`PERIPH_LED_W-1:0] led_oe;
  logic                     uart_td;
  logic                     rx_valid;
  logic [7:0]               rx_data;
  int                       rx_bit_clks;
  logic                     rx_stop_ok;
  int                       clks_per_bit;
  integer                   seed;
  int                       errors;
  int                       checks;
  logic [7:0]               exp_q[$];
  logic [7:0]               exp_byte;
  logic [31:0]              rdata;
  logic                     err;

  always #20 clk = ~clk;

  periph_top i_dut (
    .clk       (clk),
    .i_arst_n  (arst_n),
    .i_req     (req),
    .o_prdata  (prdata),
    .o_pready  (pready),
    .o_pslverr (pslverr),
    .i_sw      (sw),
    .o_led     (led),
    .o_led_oe  (led_oe),
    .o_uart_td (uart_td)
  );

  uart_rx_monitor i_rx_mon (
    .clk            (clk),
    .i_rx           (uart_td),
    .i_clks_per_bit (clks_per_bit),
    .o_valid        (rx_valid),
    .o_data         (rx_data),
    .o_bit_clks     (rx_bit_clks),
    .o_stop_ok      (rx_stop_ok)
  );

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
    end
  endtask

  // ==============================
  // APB requester
  // ==============================
  task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rd, output logic rd_err);
    @(posedge clk);
    req.psel    <= 1'b1;
    req.penable <= 1'b0;
    req.pwrite  <= wr;
    req.paddr   <= addr;
    req.pwdata  <= wdata;
    @(posedge clk);
    req.penable <= 1'b1;
    // response is valid in the access cycle
    @(negedge clk);
    rd     = prdata;
    rd_err = pslverr;
    @(posedge clk);
    req <= '0;
  endtask

  task automatic write_reg(input string name, input logic [7:0] addr,
                           input logic [31:0] data, input logic exp_err);
    logic [31:0] rd;
    logic        rd_err;
    apb_xfer(1'b1, addr, data, rd, rd_err);
    check_value({name, " pslverr"}, exp_err, rd_err);
  endtask

  task automatic read_check(input string name, input logic [7:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    logic        rd_err;
    apb_xfer(1'b0, addr, '0, rd, rd_err);
    check_value({name, " pslverr"}, 1'b0, rd_err);
    check_value(name, exp, rd);
  endtask

  // random payload, refused bytes never reach the line
  task automatic push_byte(input string name, input logic exp_err);
    logic [31:0] rnd;
    rnd = $random(seed);
    write_reg(name, REG_UART_DATA, {24'd0, rnd[7:0]}, exp_err);
    if (!exp_err) begin
      exp_q.push_back(rnd[7:0]);
    end
  endtask

  task automatic wait_rx_drain();
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
  endtask

  task automatic wait_tx_idle();
    logic [31:0] status;
    logic        status_err;
    status = '1;
    while (status[1] || !status[2]) begin
      apb_xfer(1'b0, REG_UART_STATUS, '0, status, status_err);
    end
  endtask

  // compare each received frame with the expected queue
  always @(posedge clk) begin
    if (rx_valid) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("byte %02h arrived on the serial line but none was expected", rx_data);
      end else begin
        exp_byte = exp_q.pop_front();
        check_value("uart byte", exp_byte, rx_data);
        check_value("uart bit period", clks_per_bit, rx_bit_clks);
        check_value("uart stop bit", 1'b1, rx_stop_ok);
      end
    end
  end

  a_pready_in_access: assert property (@(posedge clk) disable iff (!arst_n)
    (req.psel && req.penable) |-> pready)
    else begin
      errors++;
      $display("pready was low in an APB access cycle");
    end

  a_no_idle_error: assert property (@(posedge clk) disable iff (!arst_n)
    !(req.psel && req.penable) |-> !pslverr)
    else begin
      errors++;
      $display("pslverr was raised outside an APB access cycle");
    end

  // ==============================
  // test sequence
  // ==============================
  initial begin
    clk          = 1'b0;
    arst_n       = 1'b0;
    req          = '0;
    sw           = 4'hF;
    clks_per_bit = RST_CPB;
    seed         = 32'h25a62d5d;
    errors       = 0;
    checks       = 0;
    repeat (3) @(posedge clk);

    // reset state
    check_value("reset uart_td", 1'b1, uart_td);
    check_value("reset led_oe", '0, led_oe);
    check_value("reset pslverr", 1'b0, pslverr);
    arst_n <= 1'b1;
    read_check("reset status", REG_UART_STATUS, 32'h4);
    read_check("reset scaler", REG_UART_SCALER, RST_CPB - 1);

    // gpio
    write_reg("gpio out write", REG_GPIO_OUT, 32'hA5, 1'b0);
    write_reg("gpio dir write", REG_GPIO_DIR, 32'h3C, 1'b0);
    read_check("gpio out readback", REG_GPIO_OUT, 32'hA5);
    read_check("gpio dir readback", REG_GPIO_DIR, 32'h3C);
    check_value("led pins", 32'hA5, led);
    check_value("led enables", 32'h3C, led_oe);
    read_check("switch inputs", REG_GPIO_IN, 32'hF);

    // error responses
    apb_xfer(1'b0, 8'h18, '0, rdata, err);
    check_value("unmapped read pslverr", 1'b1, err);
    write_reg("unmapped write", 8'h18, 32'h5A, 1'b1);
    write_reg("gpio in write", REG_GPIO_IN, 32'h0, 1'b1);
    read_check("gpio in unchanged", REG_GPIO_IN, 32'hF);
    read_check("gpio out unchanged", REG_GPIO_OUT, 32'hA5);

    // uart at the reset bit period
    repeat (N_UART) push_byte("uart push", 1'b0);
    wait_rx_drain();
    wait_tx_idle();

    // first byte goes straight to the idle serializer, so depth+1 fit
    for (int i = 0; i < N_BP; i++) begin
      if (i == N_BP - 1) begin
        read_check("status full", REG_UART_STATUS, 32'h3);
      end
      push_byte("backpressure push", i == N_BP - 1);
    end
    wait_rx_drain();
    wait_tx_idle();

    // new bit period
    write_reg("scaler write", REG_UART_SCALER, NEW_SCALER, 1'b0);
    read_check("scaler readback", REG_UART_SCALER, NEW_SCALER);
    clks_per_bit = NEW_SCALER + 1;
    repeat (N_SCALE) push_byte("scaled push", 1'b0);
    wait_rx_drain();
    wait_tx_idle();
    repeat (2) @(posedge clk);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // watchdog
  initial begin
    repeat (WD_CYCLES) @(posedge clk);
    $display("timeout after %0d clock cycles, the test did not finish", WD_CYCLES);
    $display("checks: %0d, errors: %0d", checks, errors);
    $display("Errors found");
    $finish;
  end

endmodule

//--- flist.f
+incdir+common
common/periph_pkg.sv
verilog/apb_decoder.sv
verilog/gpio_regs.sv
uart/uart_tx_fifo.sv
uart/uart_tx_serializer.sv
verilog/periph_top.sv
test/uart_rx_monitor.sv
test/periph_top_tb.sv

//--- Bender.yml
package:
  name: periph

export_include_dirs:
  - common

sources:
  - files:
      - common/periph_pkg.sv
      - verilog/apb_decoder.sv
      - verilog/gpio_regs.sv
      - uart/uart_tx_fifo.sv
      - uart/uart_tx_serializer.sv
      - verilog/periph_top.sv
  - target: test
    files:
      - test/uart_rx_monitor.sv
      - test/periph_top_tb.sv
